//--- src/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

	// Primary opcodes of the supported subset
	typedef enum logic [5:0] {
		opSpecial = 6'b000000,
		opJ       = 6'b000010,
		opJal     = 6'b000011,
		opBeq     = 6'b000100,
		opOri     = 6'b001101,
		opLui     = 6'b001111,
		opLw      = 6'b100011,
		opSw      = 6'b101011
	} opcodeT;

	// Function field under opSpecial
	typedef enum logic [5:0] {
		fnNop  = 6'b000000, // sll by zero
		fnAddu = 6'b100001,
		fnSubu = 6'b100011,
		fnAnd  = 6'b100100,
		fnOr   = 6'b100101,
		fnSlt  = 6'b101010
	} functT;

	// Lowest bit of each instruction field
	localparam int opPos      = 26;
	localparam int rsPos      = 21;
	localparam int rtPos      = 16;
	localparam int rdPos      = 11;
	localparam int fnPos      = 0;
	localparam int immWidth   = 16;
	localparam int indexWidth = 26;

	localparam logic [4:0]  linkReg  = 5'd31;     // Written by jal
	localparam logic [31:0] resetPc  = 32'h0000_3000;
	localparam logic [31:0] nopInstr = {opSpecial, 20'd0, fnNop};

endpackage

`default_nettype wire

//--- src/mipsCtrlPkg.sv
`default_nettype none

package mipsCtrlPkg;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOpT;

	typedef enum logic [1:0] {npcSeq, npcBranch, npcJump} npcSelT;

	// Source of the value written back
	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSelT;

	typedef enum logic [1:0] {dstRt, dstRd, dstRa} dstSelT;

	// Operand bypass source
	typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSelT;

	localparam logic [4:0] regZero = 5'd0;

endpackage

`default_nettype wire

//--- src/controlDecoder.sv
`default_nettype none

module controlDecoder (
	input  logic [31:0]         instr,
	output mipsCtrlPkg::aluOpT  aluOp,
	output mipsCtrlPkg::npcSelT npcSel,
	output logic                isBranch,
	output logic                regWrite,
	output logic                memWrite,
	output logic                isLoad,
	output logic                aluImm,    // Operand B is the immediate
	output logic                signExt,
	output mipsCtrlPkg::dstSelT dstSel,
	output mipsCtrlPkg::wbSelT  wbSel,
	output logic                useRs,
	output logic                useRt
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	opcodeT op;
	functT  fn;
	logic   rAlu;

	assign op   = opcodeT'(instr[opPos +: 6]);
	assign fn   = functT'(instr[fnPos +: 6]);
	assign rAlu = (op == opSpecial) && (fn inside {fnAddu, fnSubu, fnAnd, fnOr, fnSlt});

	always_comb begin
		// Defaults describe a nop
		aluOp    = aluAdd;
		npcSel   = npcSeq;
		isBranch = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		isLoad   = 1'b0;
		aluImm   = 1'b0;
		signExt  = 1'b0;
		dstSel   = dstRt;
		wbSel    = wbAlu;
		useRs    = 1'b0;
		useRt    = 1'b0;
		case (op)
			opSpecial: begin
				if (rAlu) begin
					regWrite = 1'b1;
					dstSel   = dstRd;
					useRs    = 1'b1;
					useRt    = 1'b1;
				end
				case (fn)
					fnSubu:  aluOp = aluSub;
					fnAnd:   aluOp = aluAnd;
					fnOr:    aluOp = aluOr;
					fnSlt:   aluOp = aluSlt;
					default: aluOp = aluAdd;
				endcase
			end
			opOri: begin
				{regWrite, aluImm, useRs} = 3'b111;
				aluOp = aluOr;          // Zero extended
			end
			opLui: begin
				{regWrite, aluImm} = 2'b11;
				aluOp = aluLui;
			end
			opLw: begin
				{regWrite, aluImm, signExt, useRs, isLoad} = 5'b11111;
				wbSel = wbMem;
			end
			opSw: {memWrite, aluImm, signExt, useRs, useRt} = 5'b11111;
			opBeq: begin
				npcSel = npcBranch;
				{isBranch, signExt, useRs, useRt} = 4'b1111;
			end
			opJ: npcSel = npcJump;
			opJal: begin
				npcSel   = npcJump;
				regWrite = 1'b1;
				dstSel   = dstRa;
				wbSel    = wbLink;
			end
			default: ; // Unknown encodings fall through as nop
		endcase
	end

endmodule

`default_nettype wire

//--- src/regFile.sv
`default_nettype none

module regFile (
	input  logic        clk,
	input  logic        rstN,
	input  logic [4:0]  rsAddr,
	input  logic [4:0]  rtAddr,
	input  logic        wrEn,
	input  logic [4:0]  wrAddr,
	input  logic [31:0] wrData,
	output logic [31:0] rsData,
	output logic [31:0] rtData
);
	import mipsCtrlPkg::*;

	logic [31:0] regs [1:31];   // No storage behind register zero

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != regZero) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Writeback value is visible to decode in the same cycle
	always_comb begin
		if (rsAddr == regZero)
			rsData = '0;
		else if (wrEn && wrAddr == rsAddr)
			rsData = wrData;
		else
			rsData = regs[rsAddr];
	end

	always_comb begin
		if (rtAddr == regZero)
			rtData = '0;
		else if (wrEn && wrAddr == rtAddr)
			rtData = wrData;
		else
			rtData = regs[rtAddr];
	end

	// Register zero reads as zero even right after a write aimed at it
	assert property (@(posedge clk) disable iff (!rstN)
		(rsAddr == regZero |-> rsData == '0) and (rtAddr == regZero |-> rtData == '0))
		else $error("regFile: register zero read nonzero");

endmodule

`default_nettype wire

//--- src/fetchUnit.sv
`default_nettype none

module fetchUnit (
	input  logic                                clk,
	input  logic                                rstN,
	input  logic                                pcHold,
	input  mipsCtrlPkg::npcSelT                 npcSel,
	input  logic                                branchTaken,
	input  logic [mipsIsaPkg::immWidth-1:0]     branchOffset,
	input  logic [mipsIsaPkg::indexWidth-1:0]   jumpIndex,
	input  logic [31:0]                         decodePc,    // PC of the branch or jump
	output logic [31:0]                         pc
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	logic [31:0] seqPc;
	logic [31:0] branchPc;
	logic [31:0] jumpPc;
	logic [31:0] nextPc;

	assign seqPc    = pc + 32'd4;
	assign branchPc = decodePc + 32'd4
		+ {{(30 - immWidth){branchOffset[immWidth-1]}}, branchOffset, 2'b00};
	assign jumpPc   = {decodePc[31:28], jumpIndex, 2'b00};

	// Redirect lands after the delay slot now in fetch
	always_comb begin
		case (npcSel)
			npcBranch: nextPc = branchTaken ? branchPc : seqPc;
			npcJump:   nextPc = jumpPc;
			default:   nextPc = seqPc;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			pc <= resetPc;
		else if (!pcHold)
			pc <= nextPc;
	end

	assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
		else $error("fetchUnit: misaligned pc %h", pc);

endmodule

`default_nettype wire

//--- src/hazardUnit.sv
`default_nettype none

module hazardUnit (
	input  logic [4:0]          decRs,
	input  logic [4:0]          decRt,
	input  logic                decUseRs,
	input  logic                decUseRt,
	input  logic                decIsBranch,
	input  logic [4:0]          exeDst,
	input  logic                exeRegWrite,
	input  logic                exeIsLoad,
	input  logic [4:0]          exeRs,
	input  logic [4:0]          exeRt,
	input  logic [4:0]          memDst,
	input  logic                memRegWrite,
	input  logic                memIsLoad,
	input  logic [4:0]          wbDst,
	input  logic                wbRegWrite,
	output logic                pcHold,
	output logic                decodeHold,
	output logic                execBubble,
	output mipsCtrlPkg::fwdSelT decFwdRs,
	output mipsCtrlPkg::fwdSelT decFwdRt,
	output mipsCtrlPkg::fwdSelT exeFwdRs,
	output mipsCtrlPkg::fwdSelT exeFwdRt
);
	import mipsCtrlPkg::*;

	logic rsFromExe;
	logic rtFromExe;
	logic rsFromLoad;
	logic rtFromLoad;
	logic loadUse;
	logic branchWait;
	logic stall;

	function automatic logic hit(input logic [4:0] src, input logic [4:0] dst, input logic we);
		return we && (dst == src) && (dst != regZero);
	endfunction

	// Memory stage is younger so it wins over writeback
	function automatic fwdSelT exeSel(input logic [4:0] src, input logic [4:0] mDst,
			input logic mWe, input logic [4:0] wDst, input logic wWe);
		if (hit(src, mDst, mWe))
			return fwdMem;
		if (hit(src, wDst, wWe))
			return fwdWb;
		return fwdNone;
	endfunction

	assign rsFromExe  = decUseRs && hit(decRs, exeDst, exeRegWrite);
	assign rtFromExe  = decUseRt && hit(decRt, exeDst, exeRegWrite);
	assign rsFromLoad = decUseRs && memIsLoad && hit(decRs, memDst, memRegWrite);
	assign rtFromLoad = decUseRt && memIsLoad && hit(decRt, memDst, memRegWrite);

	assign loadUse    = exeIsLoad && (rsFromExe || rtFromExe);
	assign branchWait = decIsBranch && (rsFromExe || rtFromExe || rsFromLoad || rtFromLoad);
	assign stall      = loadUse || branchWait;

	assign pcHold     = stall;
	assign decodeHold = stall;
	assign execBubble = stall;

	// Decode takes only ALU and link results from memory
	assign decFwdRs = (hit(decRs, memDst, memRegWrite) && !memIsLoad) ? fwdMem : fwdNone;
	assign decFwdRt = (hit(decRt, memDst, memRegWrite) && !memIsLoad) ? fwdMem : fwdNone;
	assign exeFwdRs = exeSel(exeRs, memDst, memRegWrite, wbDst, wbRegWrite);
	assign exeFwdRt = exeSel(exeRt, memDst, memRegWrite, wbDst, wbRegWrite);

	always_comb begin
		assert #0 (execBubble == pcHold)
			else $error("hazardUnit: bubble without fetch hold");
		// The load-use stall a cycle earlier keeps a load result out of memory forwarding
		assert #0 (!(memIsLoad && (exeFwdRs == fwdMem || exeFwdRt == fwdMem)))
			else $error("hazardUnit: load result forwarded from memory stage");
	end

endmodule

`default_nettype wire

//--- src/mips.sv
`default_nettype none

module mips (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] iInstRdata,  // Same-cycle ROM answer
	input  logic [31:0] mDataRdata,
	output logic [31:0] iInstAddr,
	output logic [31:0] mDataAddr,
	output logic [31:0] mDataWdata,
	output logic [3:0]  mDataByteen,
	output logic [31:0] mInstAddr,
	output logic        wGrfWe,
	output logic [4:0]  wGrfAddr,
	output logic [31:0] wGrfWdata,
	output logic [31:0] wInstAddr
);
	import mipsIsaPkg::*;
	import mipsCtrlPkg::*;

	logic        pcHold;
	logic        decodeHold;
	logic        execBubble;
	fwdSelT      decFwdRs;
	fwdSelT      decFwdRt;
	fwdSelT      exeFwdRs;
	fwdSelT      exeFwdRt;
	// Fetch and decode
	logic [31:0] pcF;
	logic [31:0] instrD;
	logic [31:0] pcD;
	npcSelT      npcSelD;
	logic        isBranchD;
	logic        useRsD;
	logic        useRtD;
	logic        branchTaken;
	logic [31:0] rfRs;
	logic [31:0] rfRt;
	logic [31:0] rsD;
	logic [31:0] rtD;
	// Execute
	logic [31:0] instrE;
	logic [31:0] pcE;
	logic [31:0] rsE;
	logic [31:0] rtE;
	aluOpT       aluOpE;
	logic        regWriteE;
	logic        isLoadE;
	logic        aluImmE;
	logic        signExtE;
	dstSelT      dstSelE;
	wbSelT       wbSelE;
	logic        useRsE;
	logic        useRtE;
	logic [4:0]  dstE;
	logic [4:0]  exeRs;
	logic [4:0]  exeRt;
	logic [31:0] immE;
	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] storeE;
	logic [31:0] aluOut;
	logic [31:0] resultE;
	// Memory
	logic [31:0] instrM;
	logic [31:0] pcM;
	logic [31:0] aluM;     // ALU or link result
	logic [31:0] storeM;
	logic        regWriteM;
	logic        memWriteM;
	logic        isLoadM;
	dstSelT      dstSelM;
	logic [4:0]  dstM;
	// Writeback
	logic [31:0] instrW;
	logic [31:0] pcW;
	logic [31:0] aluW;
	logic [31:0] loadW;
	dstSelT      dstSelW;
	wbSelT       wbSelW;
	logic [31:0] wbData;

	function automatic logic [4:0] destReg(input logic [31:0] instr, input dstSelT sel,
			input logic we);
		if (!we)
			return regZero;
		case (sel)
			dstRd:   return instr[rdPos +: 5];
			dstRa:   return linkReg;
			default: return instr[rtPos +: 5];
		endcase
	endfunction

	function automatic logic [31:0] fwdMux(input fwdSelT sel, input logic [31:0] own,
			input logic [31:0] memVal, input logic [31:0] wbVal);
		case (sel)
			fwdMem:  return memVal;
			fwdWb:   return wbVal;
			default: return own;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Fetch

	fetchUnit fetch (.clk(clk), .rstN(rstN), .pcHold(pcHold), .npcSel(npcSelD),
		.branchTaken(branchTaken), .branchOffset(instrD[immWidth-1:0]),
		.jumpIndex(instrD[indexWidth-1:0]), .decodePc(pcD), .pc(pcF));

	assign iInstAddr = pcF;

	always_ff @(posedge clk) begin
		if (!rstN)
			instrD <= nopInstr;
		else if (!decodeHold)
			instrD <= iInstRdata;
	end

	always_ff @(posedge clk) begin
		if (!decodeHold)
			pcD <= pcF;
	end

	//////////////////////////////////////////////////////////////////////
	// Decode with branch compare

	controlDecoder decodeCtrl (.instr(instrD), .npcSel(npcSelD), .isBranch(isBranchD),
		.useRs(useRsD), .useRt(useRtD), .aluOp(), .regWrite(), .memWrite(), .isLoad(),
		.aluImm(), .signExt(), .dstSel(), .wbSel());

	regFile grf (.clk(clk), .rstN(rstN), .rsAddr(instrD[rsPos +: 5]),
		.rtAddr(instrD[rtPos +: 5]), .wrEn(wGrfWe), .wrAddr(wGrfAddr), .wrData(wbData),
		.rsData(rfRs), .rtData(rfRt));

	assign rsD = fwdMux(decFwdRs, rfRs, aluM, wbData);
	assign rtD = fwdMux(decFwdRt, rfRt, aluM, wbData);
	assign branchTaken = (rsD == rtD);    // beq only

	hazardUnit hazard (.decRs(instrD[rsPos +: 5]), .decRt(instrD[rtPos +: 5]),
		.decUseRs(useRsD), .decUseRt(useRtD), .decIsBranch(isBranchD),
		.exeDst(dstE), .exeRegWrite(regWriteE), .exeIsLoad(isLoadE),
		.exeRs(exeRs), .exeRt(exeRt),
		.memDst(dstM), .memRegWrite(regWriteM), .memIsLoad(isLoadM),
		.wbDst(wGrfAddr), .wbRegWrite(wGrfWe),
		.pcHold(pcHold), .decodeHold(decodeHold), .execBubble(execBubble),
		.decFwdRs(decFwdRs), .decFwdRt(decFwdRt), .exeFwdRs(exeFwdRs), .exeFwdRt(exeFwdRt));

	//////////////////////////////////////////////////////////////////////
	// Execute

	always_ff @(posedge clk) begin
		if (!rstN || execBubble)
			instrE <= nopInstr;   // Bubble on stall
		else
			instrE <= instrD;
	end

	always_ff @(posedge clk) begin
		pcE <= pcD;
		rsE <= rsD;
		rtE <= rtD;
	end

	controlDecoder execCtrl (.instr(instrE), .aluOp(aluOpE), .regWrite(regWriteE),
		.isLoad(isLoadE), .aluImm(aluImmE), .signExt(signExtE), .dstSel(dstSelE),
		.wbSel(wbSelE), .useRs(useRsE), .useRt(useRtE), .npcSel(), .isBranch(),
		.memWrite());

	assign dstE  = destReg(instrE, dstSelE, regWriteE);
	// Unread fields must not pull in a forward
	assign exeRs = useRsE ? instrE[rsPos +: 5] : regZero;
	assign exeRt = useRtE ? instrE[rtPos +: 5] : regZero;

	assign immE = signExtE ? {{(32 - immWidth){instrE[immWidth-1]}}, instrE[immWidth-1:0]}
		: {{(32 - immWidth){1'b0}}, instrE[immWidth-1:0]};
	assign srcA   = fwdMux(exeFwdRs, rsE, aluM, wbData);
	assign storeE = fwdMux(exeFwdRt, rtE, aluM, wbData);
	assign srcB   = aluImmE ? immE : storeE;

	always_comb begin
		case (aluOpE)
			aluSub:  aluOut = srcA - srcB;
			aluAnd:  aluOut = srcA & srcB;
			aluOr:   aluOut = srcA | srcB;
			aluSlt:  aluOut = {31'd0, $signed(srcA) < $signed(srcB)};
			aluLui:  aluOut = {srcB[15:0], 16'd0};
			default: aluOut = srcA + srcB;
		endcase
	end

	assign resultE = (wbSelE == wbLink) ? pcE + 32'd8 : aluOut;

	//////////////////////////////////////////////////////////////////////
	// Memory

	always_ff @(posedge clk) begin
		if (!rstN)
			instrM <= nopInstr;
		else
			instrM <= instrE;
	end

	always_ff @(posedge clk) begin
		pcM    <= pcE;
		aluM   <= resultE;
		storeM <= storeE;
	end

	controlDecoder memCtrl (.instr(instrM), .regWrite(regWriteM), .memWrite(memWriteM),
		.isLoad(isLoadM), .dstSel(dstSelM), .aluOp(), .npcSel(), .isBranch(), .aluImm(),
		.signExt(), .wbSel(), .useRs(), .useRt());

	assign dstM        = destReg(instrM, dstSelM, regWriteM);
	assign mDataAddr   = aluM;
	assign mDataWdata  = storeM;
	assign mDataByteen = memWriteM ? 4'hF : 4'h0;   // Word stores only
	assign mInstAddr   = pcM;

	assert property (@(posedge clk) disable iff (!rstN) mDataByteen inside {4'h0, 4'hF})
		else $error("mips: partial byte enable %h", mDataByteen);

	//////////////////////////////////////////////////////////////////////
	// Writeback

	always_ff @(posedge clk) begin
		if (!rstN)
			instrW <= nopInstr;
		else
			instrW <= instrM;
	end

	always_ff @(posedge clk) begin
		pcW   <= pcM;
		aluW  <= aluM;
		loadW <= mDataRdata;
	end

	controlDecoder wbCtrl (.instr(instrW), .regWrite(wGrfWe), .dstSel(dstSelW),
		.wbSel(wbSelW), .aluOp(), .npcSel(), .isBranch(), .memWrite(), .isLoad(),
		.aluImm(), .signExt(), .useRs(), .useRt());

	assign wbData    = (wbSelW == wbMem) ? loadW : aluW;
	assign wGrfAddr  = destReg(instrW, dstSelW, wGrfWe);
	assign wGrfWdata = wbData;
	assign wInstAddr = pcW;

endmodule

`default_nettype wire

//--- tests/tbMemory.sv
`default_nettype none

module tbMemory (
	input  logic        clk,
	input  logic [31:0] iInstAddr,
	output logic [31:0] iInstRdata,
	input  logic [31:0] mDataAddr,
	input  logic [31:0] mDataWdata,
	input  logic [3:0]  mDataByteen,
	output logic [31:0] mDataRdata
);
	timeunit 1ns;
	timeprecision 1ps;
	import mipsIsaPkg::*;

	localparam int romWords = 256;
	localparam int ramWords = 1024;

	logic [31:0] rom [romWords];
	logic [31:0] ram [ramWords];
	logic [31:0] romOffset;
	logic [31:0] byteMask;

	initial begin
		for (int i = 0; i < romWords; i++)
			rom[i[7:0]] = nopInstr;
		for (int i = 0; i < ramWords; i++)
			ram[i[9:0]] = '0;
	end

	task automatic writeRom(input logic [7:0] index, input logic [31:0] word);
		rom[index] = word;
	endtask

	task automatic writeRam(input logic [9:0] index, input logic [31:0] word);
		ram[index] <= word;
	endtask

	// Fetches outside the program window see nops
	assign romOffset  = iInstAddr - resetPc;
	assign iInstRdata = (romOffset < 32'(romWords * 4)) ? rom[romOffset[9:2]] : nopInstr;
	assign mDataRdata = ram[mDataAddr[11:2]];   // Same-cycle read

	assign byteMask = {{8{mDataByteen[3]}}, {8{mDataByteen[2]}},
		{8{mDataByteen[1]}}, {8{mDataByteen[0]}}};

	always @(posedge clk) begin
		if (mDataByteen != 4'h0)
			ram[mDataAddr[11:2]] <= (ram[mDataAddr[11:2]] & ~byteMask) | (mDataWdata & byteMask);
	end

endmodule

`default_nettype wire

//--- tests/tbMips.sv
`default_nettype none

module tbMips;
	timeunit 1ns;
	timeprecision 1ps;
	import mipsIsaPkg::*;

	localparam int maxProg       = 256;
	localparam int ramWords      = 1024;
	localparam int timeoutCycles = 2000;
	localparam int stepLimit     = 1000;

	logic        clk;
	logic        rstN;
	logic [31:0] iInstAddr;
	logic [31:0] iInstRdata;
	logic [31:0] mDataAddr;
	logic [31:0] mDataWdata;
	logic [3:0]  mDataByteen;
	logic [31:0] mDataRdata;
	logic [31:0] mInstAddr;
	logic        wGrfWe;
	logic [4:0]  wGrfAddr;
	logic [31:0] wGrfWdata;
	logic [31:0] wInstAddr;

	logic [31:0] prog [maxProg];
	logic [31:0] expPc [$];      // Expected register writes in order
	logic [4:0]  expReg [$];
	logic [31:0] expVal [$];
	logic [31:0] expStPc [$];    // Expected stores in order
	logic [31:0] expStAddr [$];
	logic [31:0] expStData [$];
	logic [31:0] fetchLimit;     // Delay slot of the final loop
	bit          checking;
	int          errors;
	int          testErrors;
	int          writesSeen;
	int          storesSeen;

	tbMemory mem (.*);
	mips UUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Program generation

	function automatic logic [31:0] fillWord(input logic [31:0] index, input logic [31:0] progId);
		return (index * 32'h9E37_79B9) ^ progId;
	endfunction

	function automatic logic [31:0] encodeR(input functT fn, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt);
		return {opSpecial, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(input opcodeT op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeJ(input opcodeT op, input logic [31:0] target);
		return {op, target[27:2]};
	endfunction

	// Small pool keeps dependencies dense
	task automatic pickReg(input int mode, output logic [4:0] r);
		if (mode == 5)
			r = 5'($urandom % 3);
		else if ($urandom % 10 == 0)
			r = 5'd31;
		else
			r = 5'($urandom % 8);
	endtask

	// Modes: 1 ALU, 2 load/store, 3 beq, 4 j/jal, 5 register zero, 6 everything
	task automatic genProgram(input int mode, input int len);
		int          kind;
		int          target;
		bit          prevCtrl;
		logic [4:0]  rd;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
		logic [15:0] dataOff;
		prevCtrl = 1'b0;
		for (int i = 0; i < len; i++) begin
			kind = $urandom % 7;
			if ($urandom % 3 == 0) begin
				case (mode)
					2: kind = 7 + $urandom % 2;
					3: kind = 9;
					4: kind = 10 + $urandom % 2;
					6: kind = 7 + $urandom % 5;
					default: ;
				endcase
			end
			// Delay slots and the last slot stay free of control transfers
			if (kind >= 9 && (prevCtrl || i >= len - 1))
				kind = 5;
			pickReg(mode, rd);
			pickReg(mode, rs);
			pickReg(mode, rt);
			imm     = 16'($urandom);
			dataOff = {8'd0, 6'($urandom), 2'b00};
			target  = 0;
			if (kind >= 9)
				target = i + 2 + $urandom % (len - i - 1);   // Forward only
			case (kind)
				0: prog[i[7:0]] = encodeR(fnAddu, rd, rs, rt);
				1: prog[i[7:0]] = encodeR(fnSubu, rd, rs, rt);
				2: prog[i[7:0]] = encodeR(fnAnd, rd, rs, rt);
				3: prog[i[7:0]] = encodeR(fnOr, rd, rs, rt);
				4: prog[i[7:0]] = encodeR(fnSlt, rd, rs, rt);
				5: prog[i[7:0]] = encodeI(opOri, rs, rd, imm);
				6: prog[i[7:0]] = encodeI(opLui, 5'd0, rd, imm);
				7: prog[i[7:0]] = encodeI(opLw, 5'd0, rd, dataOff);
				8: prog[i[7:0]] = encodeI(opSw, 5'd0, rt, dataOff);
				9: prog[i[7:0]] = encodeI(opBeq, rs, rt, 16'(target - i - 1));
				10: prog[i[7:0]] = encodeJ(opJ, resetPc + 32'(4 * target));
				default: prog[i[7:0]] = encodeJ(opJal, resetPc + 32'(4 * target));
			endcase
			prevCtrl = (kind >= 9);
		end
		prog[len[7:0]] = encodeJ(opJ, resetPc + 32'(4 * len));   // Final self-loop
		for (int i = len + 1; i < maxProg; i++)
			prog[i[7:0]] = nopInstr;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Instruction-set model with one delay slot

	function automatic int refExecute(input int len, input logic [31:0] progId);
		logic [31:0] regs [32];
		logic [31:0] ram [ramWords];
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nextNpc;
		logic [31:0] pcOff;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] addr;
		logic [31:0] val;
		logic [4:0]  dst;
		bit          writes;
		int          steps;
		for (int r = 0; r < 32; r++)
			regs[r[4:0]] = '0;
		for (int w = 0; w < ramWords; w++)
			ram[w[9:0]] = fillWord(w, progId);
		pc    = resetPc;
		npc   = resetPc + 32'd4;
		steps = 0;
		while (pc != resetPc + 32'(4 * len) && steps < stepLimit) begin
			pcOff   = pc - resetPc;
			ins     = prog[pcOff[9:2]];
			a       = regs[ins[25:21]];
			b       = regs[ins[20:16]];
			simm    = {{16{ins[15]}}, ins[15:0]};
			nextNpc = npc + 32'd4;
			writes  = 1'b1;
			dst     = ins[20:16];
			val     = '0;
			case (ins[31:26])
				opSpecial: begin
					dst = ins[15:11];
					case (ins[5:0])
						fnAddu:  val = a + b;
						fnSubu:  val = a - b;
						fnAnd:   val = a & b;
						fnOr:    val = a | b;
						fnSlt:   val = {31'd0, $signed(a) < $signed(b)};
						default: writes = 1'b0;
					endcase
				end
				opOri: val = a | {16'd0, ins[15:0]};
				opLui: val = {ins[15:0], 16'd0};
				opLw: begin
					addr = a + simm;
					val  = ram[addr[11:2]];
				end
				opSw: begin
					addr = a + simm;
					ram[addr[11:2]] = b;
					expStPc.push_back(pc);
					expStAddr.push_back(addr);
					expStData.push_back(b);
					writes = 1'b0;
				end
				opBeq: begin
					writes = 1'b0;
					if (a == b)
						nextNpc = pc + 32'd4 + {simm[29:0], 2'b00};
				end
				opJ: begin
					writes  = 1'b0;
					nextNpc = {pc[31:28], ins[25:0], 2'b00};
				end
				opJal: begin
					dst     = 5'd31;
					val     = pc + 32'd8;   // Return past the delay slot
					nextNpc = {pc[31:28], ins[25:0], 2'b00};
				end
				default: writes = 1'b0;
			endcase
			if (writes) begin
				expPc.push_back(pc);
				expReg.push_back(dst);
				expVal.push_back(val);
				if (dst != 5'd0)
					regs[dst] = val;
			end
			pc  = npc;
			npc = nextNpc;
			steps++;
		end
		return steps;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Trace checks

	task automatic checkWrite();
		if (expPc.size() == 0) begin
			$display("Unexpected write of r%0d from pc %h after the program ended",
				wGrfAddr, wInstAddr);
			testErrors++;
			return;
		end
		if (wInstAddr != expPc[0]) begin
			$display("FAIL wInstAddr = %h, expected %h", wInstAddr, expPc[0]);
			testErrors++;
		end
		if (wGrfAddr != expReg[0]) begin
			$display("FAIL wGrfAddr = %h, expected %h (pc %h)", wGrfAddr, expReg[0], expPc[0]);
			testErrors++;
		end
		if (wGrfWdata != expVal[0]) begin
			$display("FAIL wGrfWdata = %h, expected %h (pc %h)", wGrfWdata, expVal[0], expPc[0]);
			testErrors++;
		end
		void'(expPc.pop_front());
		void'(expReg.pop_front());
		void'(expVal.pop_front());
		writesSeen++;
	endtask

	task automatic checkStore();
		if (expStAddr.size() == 0) begin
			$display("Unexpected store to %h from pc %h", mDataAddr, mInstAddr);
			testErrors++;
			return;
		end
		if (mDataByteen != 4'hF) begin
			$display("FAIL mDataByteen = %h, expected f", mDataByteen);
			testErrors++;
		end
		if (mInstAddr != expStPc[0]) begin
			$display("FAIL mInstAddr = %h, expected %h", mInstAddr, expStPc[0]);
			testErrors++;
		end
		if (mDataAddr != expStAddr[0]) begin
			$display("FAIL mDataAddr = %h, expected %h", mDataAddr, expStAddr[0]);
			testErrors++;
		end
		if (mDataWdata != expStData[0]) begin
			$display("FAIL mDataWdata = %h, expected %h", mDataWdata, expStData[0]);
			testErrors++;
		end
		void'(expStPc.pop_front());
		void'(expStAddr.pop_front());
		void'(expStData.pop_front());
		storesSeen++;
	endtask

	// Fetch stays aligned and never runs past the loop's delay slot
	task automatic checkFetch();
		if (iInstAddr < resetPc || iInstAddr > fetchLimit || iInstAddr[1:0] != 2'b00) begin
			$display("FAIL iInstAddr = %h, expected %h to %h", iInstAddr, resetPc, fetchLimit);
			testErrors++;
		end
	endtask

	// Outputs settle after the rising edge
	always @(negedge clk) begin
		if (checking)
			checkFetch();
		if (checking && wGrfWe)
			checkWrite();
		if (checking && mDataByteen != 4'h0)
			checkStore();
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencing

	task automatic runProgram(input int mode, input int len, input logic [31:0] progId);
		int cycles;
		int executed;
		@(posedge clk);
		rstN     <= 1'b0;
		checking = 1'b0;
		genProgram(mode, len);
		for (int i = 0; i < maxProg; i++)
			mem.writeRom(i[7:0], prog[i[7:0]]);
		for (int w = 0; w < ramWords; w++)
			mem.writeRam(w[9:0], fillWord(w, progId));
		expPc.delete();
		expReg.delete();
		expVal.delete();
		expStPc.delete();
		expStAddr.delete();
		expStData.delete();
		fetchLimit = resetPc + 32'(4 * (len + 1));
		executed = refExecute(len, progId);
		if (executed >= stepLimit) begin
			$display("Model never reached the final loop of program %h", progId);
			testErrors++;
		end
		repeat (2) @(posedge clk);
		rstN     <= 1'b1;
		checking = 1'b1;
		cycles   = 0;
		while ((expPc.size() != 0 || expStAddr.size() != 0) && cycles < timeoutCycles) begin
			@(posedge clk);
			cycles++;
		end
		if (expPc.size() != 0 || expStAddr.size() != 0) begin
			$display("Timeout on program %h with %0d writes and %0d stores still missing",
				progId, expPc.size(), expStAddr.size());
			testErrors++;
		end
		repeat (16) @(posedge clk);   // Window for stray writes after the loop
		checking = 1'b0;
	endtask

	function automatic string testName(input int t);
		case (t)
			1: return "dependent ALU chains";
			2: return "loads and stores";
			3: return "branches";
			4: return "jumps and links";
			5: return "register zero";
			default: return "mixed random";
		endcase
	endfunction

	initial begin
		int progs;
		int len;
		void'($urandom(80));
		rstN       = 1'b0;
		checking   = 1'b0;
		fetchLimit = resetPc;
		errors     = 0;
		writesSeen = 0;
		storesSeen = 0;
		for (int t = 1; t <= 6; t++) begin
			testErrors = 0;
			progs = (t == 6) ? 40 : 6;
			len   = (t == 6) ? 60 : 30;
			for (int p = 0; p < progs; p++)
				runProgram(t, len, 32'(t * 100 + p));
			errors += testErrors;
			$display("Test %0d %s: %0d programs, %0d errors", t, testName(t), progs, testErrors);
		end
		$display("Checked %0d register writes and %0d stores, %0d errors",
			writesSeen, storesSeen, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- mips.f
src/mipsIsaPkg.sv
src/mipsCtrlPkg.sv
src/controlDecoder.sv
src/regFile.sv
src/fetchUnit.sv
src/hazardUnit.sv
src/mips.sv
tests/tbMemory.sv
tests/tbMips.sv

//--- Makefile
BIN = obj_dir/VtbMips

.PHONY: compile run clean

compile:
	verilator --binary --assert --timescale 1ns/1ps --top-module tbMips -f mips.f -Mdir obj_dir

run: compile
	./$(BIN) | tee /dev/stderr | grep -F "TB PASSED" > /dev/null

clean:
	rm -rf obj_dir
